// ==== design/cpu_pkg.sv ====
package cpu_pkg;

   // ==============================
   // basic widths
   // ==============================

   // data, instruction word or pc
   typedef logic [31:0] word_t;
   // architectural register number
   typedef logic [4:0]  reg_idx_t;
   // exception code as in estat.ecode
   typedef logic [5:0]  exccode_t;
   // alu operation select
   typedef logic [3:0]  alu_op_t;

   // syscall is the only exception left
   localparam exccode_t EXC_SYS = 6'h0b;

   // ==============================
   // alu operations
   // ==============================

   localparam alu_op_t ALU_ADD = 4'd0;
   localparam alu_op_t ALU_SUB = 4'd1;
   localparam alu_op_t ALU_AND = 4'd2;
   localparam alu_op_t ALU_OR  = 4'd3;
   localparam alu_op_t ALU_XOR = 4'd4;
   // immediate straight through, for lu12i.w
   localparam alu_op_t ALU_LUI = 4'd5;

   // ==============================
   // opcode fields
   // ==============================

   // 3R format, inst[31:15]
   localparam logic [16:0] OPC_ADD_W   = 17'h00020;
   localparam logic [16:0] OPC_SUB_W   = 17'h00022;
   localparam logic [16:0] OPC_AND     = 17'h00029;
   localparam logic [16:0] OPC_OR      = 17'h0002a;
   localparam logic [16:0] OPC_XOR     = 17'h0002b;

   // 2RI12 format, inst[31:22]
   localparam logic [9:0]  OPC_ADDI_W  = 10'h00a;

   // 1RI20 format, inst[31:25]
   localparam logic [6:0]  OPC_LU12I_W = 7'h0a;

   // 2RI16 branches, inst[31:26]
   localparam logic [5:0]  OPC_BEQ     = 6'h16;
   localparam logic [5:0]  OPC_BNE     = 6'h17;

   // syscall code sits in inst[14:0]
   localparam logic [16:0] OPC_SYSCALL = 17'h00056;

   // ertn has no fields at all
   localparam word_t       OPC_ERTN    = 32'h0648_3800;

endpackage

// ==== design/cpu_fetch.sv ====
`timescale 1ns/1ps

module cpu_fetch
   import cpu_pkg::*;
#(
   parameter word_t PC_INIT = 32'h1c00_0000
) (
   input  logic  clock,
   input  logic  rst,

   // instruction memory side
   output logic  inst_req,
   output word_t inst_addr,
   output logic  inst_cancel,
   input  logic  inst_valid,
   input  word_t inst_rdata,

   // redirects from execute
   input  logic  br_taken,
   input  word_t br_target,
   input  logic  except,
   input  word_t eentry,
   input  logic  ertn,
   input  word_t era,

   // toward decode
   output logic  dec_valid,
   output word_t dec_inst,
   output word_t dec_pc,
   output word_t pc_e
);

   word_t pc_bf;
   word_t pc_f;
   word_t pcinc_f;
   word_t pc_d;
   logic  redirect;

   // any redirect in execute kills the word now returning
   assign redirect = br_taken | except | ertn;

   // ==============================
   // pc before fetch
   // ==============================

   assign pcinc_f = pc_f + 32'd4;

   // init, then exception, ertn, branch, increment, hold
   always_comb begin
      if (rst)
         pc_bf = PC_INIT;
      else if (except)
         pc_bf = eentry;
      else if (ertn)
         pc_bf = era;
      else if (br_taken)
         pc_bf = br_target;
      else if (inst_valid)
         pc_bf = pcinc_f;
      else
         pc_bf = pc_f;   // no word back, ask again
   end

   assign inst_addr   = pc_bf;
   assign inst_req    = ~rst;
   assign inst_cancel = redirect;

   // pc_f follows the request every cycle
   always_ff @(posedge clock) begin
      pc_f <= pc_bf;
   end

   // ==============================
   // fetched word into decode
   // ==============================

   assign dec_valid = inst_valid & ~redirect;
   assign dec_inst  = inst_rdata;
   assign dec_pc    = pc_f;   // returned word belongs to pc_f

   // stage pcs, only the decode copy needs an enable
   always_ff @(posedge clock) begin
      if (dec_valid) begin
         pc_d <= pc_f;
      end
      pc_e <= pc_d;
   end

   // no request in reset, so nothing may come back right after it
   a_no_word_after_rst: assert property (@(posedge clock) rst |=> !inst_valid);

endmodule

// ==== design/cpu_regfile.sv ====
`timescale 1ns/1ps

module cpu_regfile
   import cpu_pkg::*;
(
   input  logic     clock,
   input  logic     rst,
   // read ports
   input  reg_idx_t ra1,
   input  reg_idx_t ra2,
   output word_t    rd1,
   output word_t    rd2,
   // write port from result stage
   input  logic     we,
   input  reg_idx_t wnum,
   input  word_t    wdata
);

   word_t regs [32];

   // r0 never written, cleared in reset
   always_ff @(posedge clock) begin
      if (rst) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we && wnum != '0) begin
         regs[wnum] <= wdata;
      end
   end

   // combinational reads, r0 forced to zero
   assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
   assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// ==== design/cpu_decode.sv ====
`timescale 1ns/1ps

module cpu_decode
   import cpu_pkg::*;
(
   input  logic     clock,
   input  logic     rst,
   // from fetch
   input  logic     dec_valid,
   input  word_t    dec_inst,
   input  word_t    dec_pc,
   // kill from execute
   input  logic     flush,
   // bypass sources
   input  logic     ex_we,
   input  reg_idx_t ex_wnum,
   input  word_t    ex_wdata,
   input  logic     rf_we,
   input  reg_idx_t rf_wnum,
   input  word_t    rf_wdata,
   // register file
   output reg_idx_t ra1,
   output reg_idx_t ra2,
   input  word_t    rd1,
   input  word_t    rd2,
   // toward execute
   output logic     ex_valid_d,
   output alu_op_t  ex_op,
   output word_t    ex_src1,
   output word_t    ex_src2,
   output word_t    ex_imm,
   output reg_idx_t ex_dest,
   output logic     ex_is_br,
   output logic     ex_br_ne,
   output logic     ex_is_sys,
   output logic     ex_is_ertn,
   output logic     ex_use_imm,
   output word_t    ex_pc_d
);

   logic  d_valid;
   word_t d_inst;
   word_t d_pc;
   logic  is_add, is_sub, is_and, is_or, is_xor;
   logic  is_addi, is_lu12i, is_beq, is_bne;
   logic  writes_rd;

   // ==============================
   // decode register
   // ==============================

   always_ff @(posedge clock) begin
      if (rst)
         d_valid <= 1'b0;
      else
         d_valid <= dec_valid;
      d_inst <= dec_inst;
      d_pc   <= dec_pc;
   end

   // wrong-path slot dropped on its way out
   assign ex_valid_d = d_valid & ~flush;
   assign ex_pc_d    = d_pc;

   // opcode match
   assign is_add     = d_inst[31:15] == OPC_ADD_W;
   assign is_sub     = d_inst[31:15] == OPC_SUB_W;
   assign is_and     = d_inst[31:15] == OPC_AND;
   assign is_or      = d_inst[31:15] == OPC_OR;
   assign is_xor     = d_inst[31:15] == OPC_XOR;
   assign is_addi    = d_inst[31:22] == OPC_ADDI_W;
   assign is_lu12i   = d_inst[31:25] == OPC_LU12I_W;
   assign is_beq     = d_inst[31:26] == OPC_BEQ;
   assign is_bne     = d_inst[31:26] == OPC_BNE;
   assign ex_is_sys  = d_inst[31:15] == OPC_SYSCALL;
   assign ex_is_ertn = d_inst == OPC_ERTN;

   assign ex_is_br   = is_beq | is_bne;
   assign ex_br_ne   = is_bne;
   assign ex_use_imm = is_addi | is_lu12i;

   // unknown words fall out as add into r0, i.e. no write
   assign writes_rd = is_add | is_sub | is_and | is_or | is_xor | is_addi | is_lu12i;
   assign ex_dest   = writes_rd ? d_inst[4:0] : '0;

   always_comb begin
      if (is_sub)
         ex_op = ALU_SUB;
      else if (is_and)
         ex_op = ALU_AND;
      else if (is_or)
         ex_op = ALU_OR;
      else if (is_xor)
         ex_op = ALU_XOR;
      else if (is_lu12i)
         ex_op = ALU_LUI;
      else
         ex_op = ALU_ADD;
   end

   // branch offs16<<2, lu12i si20<<12, else si12
   always_comb begin
      if (ex_is_br)
         ex_imm = {{14{d_inst[25]}}, d_inst[25:10], 2'b00};
      else if (is_lu12i)
         ex_imm = {d_inst[24:5], 12'h000};
      else
         ex_imm = {{20{d_inst[21]}}, d_inst[21:10]};
   end

   // ==============================
   // operand read and bypass
   // ==============================

   // branches compare rj with rd
   assign ra1 = d_inst[9:5];
   assign ra2 = ex_is_br ? d_inst[4:0] : d_inst[14:10];

   // execute first, then result, then the file
   assign ex_src1 = (ex_we && ex_wnum == ra1) ? ex_wdata :
                    (rf_we && rf_wnum == ra1) ? rf_wdata : rd1;
   assign ex_src2 = (ex_we && ex_wnum == ra2) ? ex_wdata :
                    (rf_we && rf_wnum == ra2) ? rf_wdata : rd2;

endmodule

// ==== design/cpu_execute.sv ====
`timescale 1ns/1ps

module cpu_execute
   import cpu_pkg::*;
#(
   parameter word_t EENTRY = 32'h1c00_0800
) (
   input  logic     clock,
   input  logic     rst,
   // from decode
   input  logic     ex_valid_d,
   input  alu_op_t  ex_op,
   input  word_t    ex_src1,
   input  word_t    ex_src2,
   input  word_t    ex_imm,
   input  reg_idx_t ex_dest,
   input  logic     ex_is_br,
   input  logic     ex_br_ne,
   input  logic     ex_is_sys,
   input  logic     ex_is_ertn,
   input  logic     ex_use_imm,
   input  word_t    ex_pc_d,
   // stage pc from the fetch chain
   input  word_t    pc_e,
   // redirects
   output logic     br_taken,
   output word_t    br_target,
   output logic     except,
   output word_t    eentry,
   output logic     ertn,
   output word_t    era,
   output logic     flush,
   // result and bypass
   output logic     ex_we,
   output reg_idx_t ex_wnum,
   output word_t    ex_wdata,
   output logic     res_valid,
   output word_t    res_pc,
   output logic     res_ex
);

   logic     x_valid;
   alu_op_t  x_op;
   word_t    x_src1;
   word_t    x_src2;
   word_t    x_imm;
   reg_idx_t x_dest;
   logic     x_is_br, x_br_ne, x_is_sys, x_is_ertn, x_use_imm;
   word_t    x_pc;
   word_t    opb;
   word_t    alu_res;
   exccode_t exc_code;
   word_t    era_q;

   // ==============================
   // execute register
   // ==============================

   always_ff @(posedge clock) begin
      if (rst)
         x_valid <= 1'b0;
      else
         x_valid <= ex_valid_d;
      x_op      <= ex_op;
      x_src1    <= ex_src1;
      x_src2    <= ex_src2;
      x_imm     <= ex_imm;
      x_dest    <= ex_dest;
      x_is_br   <= ex_is_br;
      x_br_ne   <= ex_br_ne;
      x_is_sys  <= ex_is_sys;
      x_is_ertn <= ex_is_ertn;
      x_use_imm <= ex_use_imm;
      x_pc      <= ex_pc_d;
   end

   // alu
   assign opb = x_use_imm ? x_imm : x_src2;

   always_comb begin
      case (x_op)
         ALU_SUB: alu_res = x_src1 - opb;
         ALU_AND: alu_res = x_src1 & opb;
         ALU_OR:  alu_res = x_src1 | opb;
         ALU_XOR: alu_res = x_src1 ^ opb;
         ALU_LUI: alu_res = opb;
         default: alu_res = x_src1 + opb;
      endcase
   end

   // ==============================
   // redirects
   // ==============================

   // bne flips the equality test
   assign br_taken  = x_valid & x_is_br & ((x_src1 == x_src2) ^ x_br_ne);
   assign br_target = x_pc + x_imm;

   // pending exception code, zero when none
   assign exc_code = x_is_sys ? EXC_SYS : '0;
   assign except   = x_valid & (exc_code != '0);
   assign eentry   = EENTRY;

   assign ertn = x_valid & x_is_ertn;
   assign era  = era_q;

   // return address is the syscall itself
   always_ff @(posedge clock) begin
      if (except) begin
         era_q <= pc_e;
      end
   end

   assign flush = br_taken | except | ertn;

   // write back, r0 never written
   assign ex_we    = x_valid & (x_dest != '0);
   assign ex_wnum  = x_dest;
   assign ex_wdata = alu_res;

   assign res_valid = x_valid;
   assign res_pc    = pc_e;
   assign res_ex    = except;

   // decode sets at most one class per word
   a_one_redirect: assert property (@(posedge clock) disable iff (rst)
      $onehot0({except, ertn, br_taken}));

endmodule

// ==== design/cpu_result.sv ====
`timescale 1ns/1ps

module cpu_result
   import cpu_pkg::*;
(
   input  logic     clock,
   input  logic     rst,
   // from execute
   input  logic     res_valid,
   input  word_t    res_pc,
   input  logic     res_ex,
   input  logic     ex_we,
   input  reg_idx_t ex_wnum,
   input  word_t    ex_wdata,
   // register file write
   output logic     rf_we,
   output reg_idx_t rf_wnum,
   output word_t    rf_wdata,
   // debug retire port
   output logic     wb_valid,
   output word_t    wb_pc,
   output logic     wb_rf_we,
   output reg_idx_t wb_rf_wnum,
   output word_t    wb_rf_wdata,
   output logic     wb_ex
);

   logic     r_valid;
   logic     r_we;
   logic     r_ex;
   word_t    r_pc;
   reg_idx_t r_wnum;
   word_t    r_wdata;

   // result register
   always_ff @(posedge clock) begin
      if (rst) begin
         r_valid <= 1'b0;
         r_we    <= 1'b0;
         r_ex    <= 1'b0;
      end else begin
         r_valid <= res_valid;
         r_we    <= ex_we;
         r_ex    <= res_ex;
      end
      r_pc    <= res_pc;
      r_wnum  <= ex_wnum;
      r_wdata <= ex_wdata;
   end

   // same values go to the file and to the debug port
   assign rf_we    = r_we;
   assign rf_wnum  = r_wnum;
   assign rf_wdata = r_wdata;

   assign wb_valid    = r_valid;
   assign wb_pc       = r_pc;
   assign wb_rf_we    = r_we;
   assign wb_rf_wnum  = r_wnum;
   assign wb_rf_wdata = r_wdata;
   assign wb_ex       = r_ex;

   // a write only comes from a live instruction in execute
   a_we_has_valid: assert property (@(posedge clock) disable iff (rst)
      wb_rf_we |-> wb_valid);

endmodule

// ==== design/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top
   import cpu_pkg::*;
#(
   parameter word_t PC_INIT = 32'h1c00_0000,
   parameter word_t EENTRY  = 32'h1c00_0800
) (
   input  logic     clock,
   input  logic     rst,
   // instruction fetch
   output logic     inst_req,
   output word_t    inst_addr,
   output logic     inst_cancel,
   input  logic     inst_valid,
   input  word_t    inst_rdata,
   // retire port
   output logic     wb_valid,
   output word_t    wb_pc,
   output logic     wb_rf_we,
   output reg_idx_t wb_rf_wnum,
   output word_t    wb_rf_wdata,
   output logic     wb_ex
);

   // fetch to decode
   logic     dec_valid;
   word_t    dec_inst, dec_pc, pc_e;
   // redirects
   logic     br_taken, except, ertn, flush;
   word_t    br_target, eentry, era;
   // decode to execute
   logic     ex_valid_d, ex_is_br, ex_br_ne, ex_is_sys, ex_is_ertn, ex_use_imm;
   alu_op_t  ex_op;
   word_t    ex_src1, ex_src2, ex_imm, ex_pc_d;
   reg_idx_t ex_dest;
   // register file
   reg_idx_t ra1, ra2;
   word_t    rd1, rd2;
   // execute and result writes
   logic     ex_we, rf_we, res_valid, res_ex;
   reg_idx_t ex_wnum, rf_wnum;
   word_t    ex_wdata, rf_wdata, res_pc;

   cpu_fetch #(.PC_INIT(PC_INIT)) i_fetch (
      .clock, .rst, .inst_req, .inst_addr, .inst_cancel, .inst_valid, .inst_rdata,
      .br_taken, .br_target, .except, .eentry, .ertn, .era,
      .dec_valid, .dec_inst, .dec_pc, .pc_e
   );

   cpu_decode i_decode (
      .clock, .rst, .dec_valid, .dec_inst, .dec_pc, .flush,
      .ex_we, .ex_wnum, .ex_wdata, .rf_we, .rf_wnum, .rf_wdata,
      .ra1, .ra2, .rd1, .rd2,
      .ex_valid_d, .ex_op, .ex_src1, .ex_src2, .ex_imm, .ex_dest,
      .ex_is_br, .ex_br_ne, .ex_is_sys, .ex_is_ertn, .ex_use_imm, .ex_pc_d
   );

   cpu_regfile i_regfile (
      .clock, .rst, .ra1, .ra2, .rd1, .rd2,
      .we(rf_we), .wnum(rf_wnum), .wdata(rf_wdata)
   );

   cpu_execute #(.EENTRY(EENTRY)) i_execute (
      .clock, .rst,
      .ex_valid_d, .ex_op, .ex_src1, .ex_src2, .ex_imm, .ex_dest,
      .ex_is_br, .ex_br_ne, .ex_is_sys, .ex_is_ertn, .ex_use_imm, .ex_pc_d, .pc_e,
      .br_taken, .br_target, .except, .eentry, .ertn, .era, .flush,
      .ex_we, .ex_wnum, .ex_wdata, .res_valid, .res_pc, .res_ex
   );

   cpu_result i_result (
      .clock, .rst, .res_valid, .res_pc, .res_ex, .ex_we, .ex_wnum, .ex_wdata,
      .rf_we, .rf_wnum, .rf_wdata,
      .wb_valid, .wb_pc, .wb_rf_we, .wb_rf_wnum, .wb_rf_wdata, .wb_ex
   );

endmodule

// ==== sim/tb_cpu_top.sv ====
`timescale 1ns/1ps

module tb_cpu_top
   import cpu_pkg::*;
();

   localparam word_t PC_INIT     = 32'h1c00_0000;
   localparam word_t EENTRY      = 32'h1c00_0800;
   localparam int    PROG_WORDS  = 20;
   localparam int    HND_WORDS   = 3;
   localparam int    DRIVE_DELAY = 1;

   logic     clock;
   logic     rst;
   logic     inst_req;
   word_t    inst_addr;
   logic     inst_cancel;
   logic     inst_valid;
   word_t    inst_rdata;
   logic     wb_valid;
   word_t    wb_pc;
   logic     wb_rf_we;
   reg_idx_t wb_rf_wnum;
   word_t    wb_rf_wdata;
   logic     wb_ex;

   // main program at PC_INIT, handler at EENTRY
   word_t    prog [PROG_WORDS];
   word_t    hnd [HND_WORDS];
   // expected retire stream, in program order
   word_t    exp_pc [$];
   logic     exp_we [$];
   reg_idx_t exp_wnum [$];
   word_t    exp_wdata [$];
   logic     exp_ex [$];
   logic     exp_redir [$];

   integer   seed;
   int       errors;
   int       checks;
   int       exp_idx;
   logic     tables_ready;
   logic     cancel_seen;

   cpu_top #(.PC_INIT(PC_INIT), .EENTRY(EENTRY)) i_cpu_top (
      .clock, .rst, .inst_req, .inst_addr, .inst_cancel, .inst_valid, .inst_rdata,
      .wb_valid, .wb_pc, .wb_rf_we, .wb_rf_wnum, .wb_rf_wdata, .wb_ex
   );

   initial begin
      clock = 1'b0;
      forever #4 clock = ~clock;
   end

   // ==============================
   // instruction encoding
   // ==============================

   function automatic word_t three_reg(input logic [16:0] opc, input reg_idx_t rd,
                                       input reg_idx_t rj, input reg_idx_t rk);
      return {opc, rk, rj, rd};
   endfunction

   function automatic word_t addi_w(input reg_idx_t rd, input reg_idx_t rj,
                                    input logic [11:0] si12);
      return {OPC_ADDI_W, si12, rj, rd};
   endfunction

   function automatic word_t lu12i_w(input reg_idx_t rd, input logic [19:0] si20);
      return {OPC_LU12I_W, si20, rd};
   endfunction

   // offset in bytes, a multiple of 4
   function automatic word_t branch_to(input logic [5:0] opc, input reg_idx_t rj,
                                       input reg_idx_t rd, input int offs);
      logic [31:0] o;
      o = offs;
      return {opc, o[17:2], rj, rd};
   endfunction

   // memory lookup, anything outside the two tables gets a fill word
   function automatic word_t read_word(input word_t addr);
      word_t off_m;
      word_t off_h;
      off_m = addr - PC_INIT;
      off_h = addr - EENTRY;
      if (off_m < 4 * PROG_WORDS)
         return prog[off_m >> 2];
      else if (off_h < 4 * HND_WORDS)
         return hnd[off_h >> 2];
      else
         return ~addr;
   endfunction

   task automatic expect_retire(input word_t pc, input logic we, input reg_idx_t wnum,
                                input word_t wdata, input logic ex, input logic redir);
      exp_pc.push_back(pc);
      exp_we.push_back(we);
      exp_wnum.push_back(wnum);
      exp_wdata.push_back(wdata);
      exp_ex.push_back(ex);
      exp_redir.push_back(redir);
   endtask

   // ==============================
   // compare tasks
   // ==============================

   task automatic check_word(input string name, input word_t got, input word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   // ==============================
   // memory model
   // ==============================

   // answers one cycle after the request, drops about one in four
   initial begin
      logic  req_q;
      word_t addr_q;
      logic  hold_back;
      seed       = 32'hdbc5_cee7;
      inst_valid = 1'b0;
      inst_rdata = '0;
      @(posedge clock);
      forever begin
         @(negedge clock);
         req_q     = inst_req;
         addr_q    = inst_addr;
         hold_back = ($random(seed) & 3) == 0;
         @(posedge clock);
         #DRIVE_DELAY;
         inst_valid = req_q & ~hold_back;
         inst_rdata = read_word(addr_q);
      end
   end

   // watchdog, limit follows the retire table length
   initial begin
      int limit;
      int cycles;
      cycles = 0;
      wait (tables_ready);
      limit = 8 * exp_pc.size() + 100;
      while (cycles < limit) begin
         @(posedge clock);
         cycles++;
      end
      $display("timeout after %0d cycles, retire entry %0d at pc %h never retired",
               cycles, exp_idx, exp_pc[exp_idx]);
      $display("checks: %0d, errors: %0d", checks, errors);
      $display("Finished with errors");
      $finish;
   end

   // ==============================
   // program and checks
   // ==============================

   initial begin
      errors       = 0;
      checks       = 0;
      exp_idx      = 0;
      tables_ready = 1'b0;
      cancel_seen  = 1'b0;
      rst          = 1'b1;

      // constants from lu12i.w and addi.w
      prog[0]  = lu12i_w(5'd1, 20'h12345);
      prog[1]  = addi_w(5'd1, 5'd1, 12'h678);
      prog[2]  = lu12i_w(5'd2, 20'h0f0f0);
      prog[3]  = addi_w(5'd2, 5'd2, 12'hff0);
      // back to back dependency chain
      prog[4]  = three_reg(OPC_ADD_W, 5'd3, 5'd1, 5'd2);
      prog[5]  = three_reg(OPC_SUB_W, 5'd4, 5'd3, 5'd2);
      prog[6]  = three_reg(OPC_XOR, 5'd5, 5'd4, 5'd2);
      prog[7]  = three_reg(OPC_AND, 5'd6, 5'd5, 5'd3);
      prog[8]  = three_reg(OPC_OR, 5'd7, 5'd6, 5'd1);
      // r0 write dropped, then r0 read right behind it
      prog[9]  = three_reg(OPC_ADD_W, 5'd0, 5'd7, 5'd1);
      prog[10] = addi_w(5'd8, 5'd0, 12'h123);
      // r1 == r4, beq skips two words, bne falls through
      prog[11] = branch_to(OPC_BEQ, 5'd1, 5'd4, 12);
      prog[12] = addi_w(5'd10, 5'd0, 12'h7ff);
      prog[13] = addi_w(5'd10, 5'd0, 12'h7fe);
      prog[14] = branch_to(OPC_BNE, 5'd1, 5'd4, 8);
      prog[15] = addi_w(5'd11, 5'd0, 12'h0aa);
      prog[16] = {OPC_SYSCALL, 15'h0};
      prog[17] = addi_w(5'd12, 5'd0, 12'h666);
      prog[18] = addi_w(5'd13, 5'd8, 12'h0bb);
      // park on a self loop
      prog[19] = branch_to(OPC_BEQ, 5'd0, 5'd0, 0);
      hnd[0]   = addi_w(5'd14, 5'd11, 12'h00e);
      hnd[1]   = OPC_ERTN;
      hnd[2]   = addi_w(5'd15, 5'd0, 12'h555);

      // pc, we, wnum, wdata, ex, redirect raised while in execute
      expect_retire(PC_INIT + 32'h00, 1'b1, 5'd1, 32'h1234_5000, 1'b0, 1'b0);
      expect_retire(PC_INIT + 32'h04, 1'b1, 5'd1, 32'h1234_5678, 1'b0, 1'b0);
      expect_retire(PC_INIT + 32'h08, 1'b1, 5'd2, 32'h0f0f_0000, 1'b0, 1'b0);
      expect_retire(PC_INIT + 32'h0c, 1'b1, 5'd2, 32'h0f0e_fff0, 1'b0, 1'b0);
      expect_retire(PC_INIT + 32'h10, 1'b1, 5'd3, 32'h2143_5668, 1'b0, 1'b0);
      expect_retire(PC_INIT + 32'h14, 1'b1, 5'd4, 32'h1234_5678, 1'b0, 1'b0);
      expect_retire(PC_INIT + 32'h18, 1'b1, 5'd5, 32'h1d3a_a988, 1'b0, 1'b0);
      expect_retire(PC_INIT + 32'h1c, 1'b1, 5'd6, 32'h0102_0008, 1'b0, 1'b0);
      expect_retire(PC_INIT + 32'h20, 1'b1, 5'd7, 32'h1336_5678, 1'b0, 1'b0);
      expect_retire(PC_INIT + 32'h24, 1'b0, 5'd0, 32'h0, 1'b0, 1'b0);
      expect_retire(PC_INIT + 32'h28, 1'b1, 5'd8, 32'h0000_0123, 1'b0, 1'b0);
      expect_retire(PC_INIT + 32'h2c, 1'b0, 5'd0, 32'h0, 1'b0, 1'b1);
      expect_retire(PC_INIT + 32'h38, 1'b0, 5'd0, 32'h0, 1'b0, 1'b0);
      expect_retire(PC_INIT + 32'h3c, 1'b1, 5'd11, 32'h0000_00aa, 1'b0, 1'b0);
      expect_retire(PC_INIT + 32'h40, 1'b0, 5'd0, 32'h0, 1'b1, 1'b1);
      expect_retire(EENTRY + 32'h00, 1'b1, 5'd14, 32'h0000_00b8, 1'b0, 1'b0);
      expect_retire(EENTRY + 32'h04, 1'b0, 5'd0, 32'h0, 1'b0, 1'b1);
      // patched syscall slot, jumps over pc 0x44
      expect_retire(PC_INIT + 32'h40, 1'b0, 5'd0, 32'h0, 1'b0, 1'b1);
      expect_retire(PC_INIT + 32'h48, 1'b1, 5'd13, 32'h0000_01de, 1'b0, 1'b0);
      expect_retire(PC_INIT + 32'h4c, 1'b0, 5'd0, 32'h0, 1'b0, 1'b1);
      tables_ready = 1'b1;

      // reset for 5 cycles, outputs quiet inside it
      repeat (4) @(posedge clock);
      @(negedge clock);
      check_bit("inst_req", inst_req, 1'b0);
      check_bit("wb_valid", wb_valid, 1'b0);
      check_bit("wb_rf_we", wb_rf_we, 1'b0);
      check_bit("wb_ex", wb_ex, 1'b0);
      @(posedge clock);
      #DRIVE_DELAY;
      rst = 1'b0;

      // first request goes to the reset pc
      @(negedge clock);
      check_bit("inst_req", inst_req, 1'b1);
      check_word("inst_addr", inst_addr, PC_INIT);

      for (int i = 0; i < exp_pc.size(); i++) begin
         exp_idx = i;
         // cancel is seen one cycle ahead, while the entry sits in execute
         do begin
            cancel_seen = inst_cancel;
            @(negedge clock);
         end while (wb_valid !== 1'b1);
         check_word("wb_pc", wb_pc, exp_pc[i]);
         check_bit("wb_rf_we", wb_rf_we, exp_we[i]);
         check_bit("wb_ex", wb_ex, exp_ex[i]);
         check_bit("inst_cancel", cancel_seen, exp_redir[i]);
         if (exp_we[i]) begin
            check_idx("wb_rf_wnum", wb_rf_wnum, exp_wnum[i]);
            check_word("wb_rf_wdata", wb_rf_wdata, exp_wdata[i]);
         end
         // ertn comes back to the syscall word, swap in a branch-around
         if (exp_ex[i]) begin
            prog[(exp_pc[i] - PC_INIT) >> 2] = branch_to(OPC_BEQ, 5'd0, 5'd0, 8);
         end
      end

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

// ==== list.f ====
design/cpu_pkg.sv
design/cpu_fetch.sv
design/cpu_regfile.sv
design/cpu_decode.sv
design/cpu_execute.sv
design/cpu_result.sv
design/cpu_top.sv
sim/tb_cpu_top.sv

// ==== Bender.yml ====
package:
  name: cpu_top

sources:
  - design/cpu_pkg.sv
  - design/cpu_fetch.sv
  - design/cpu_regfile.sv
  - design/cpu_decode.sv
  - design/cpu_execute.sv
  - design/cpu_result.sv
  - design/cpu_top.sv
  - target: simulation
    files:
      - sim/tb_cpu_top.sv
